/* hw/periph_pkg.sv */
// Shared definitions for the timer and interrupt controller subsystem.
// Bus structs, register offset enums and the address map live here and
// are imported by every RTL block and the testbench.

package periph_pkg;

    // ----------------------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------------------
    localparam int unsigned NumTimers   = 4;
    localparam int unsigned DataWidth   = 32;
    localparam int unsigned AddrWidth   = 32;
    localparam int unsigned MaxPrio     = 7;
    localparam int unsigned PrioWidth   = $clog2(MaxPrio + 1);
    localparam int unsigned SrcIdWidth  = $clog2(NumTimers + 1);  // Id 0 is no source

    // ----------------------------------------------------------------------
    // Address map
    // ----------------------------------------------------------------------
    localparam int unsigned RegionLsb   = 8;
    localparam int unsigned RegionWidth = 4;
    localparam int unsigned OffsetLsb   = 2;   // Word aligned registers
    localparam int unsigned OffsetWidth = 4;
    localparam int unsigned IrqRegion   = 15;  // Timers take regions 0..NumTimers-1

    // APB master to slave
    typedef struct packed {
        logic                 psel;
        logic                 penable;
        logic                 pwrite;
        logic [AddrWidth-1:0] paddr;
        logic [DataWidth-1:0] pwdata;
    } apb_req_t;

    // APB slave to master
    typedef struct packed {
        logic [DataWidth-1:0] prdata;
        logic                 pready;
        logic                 pslverr;
    } apb_rsp_t;

    // Decoder to register block
    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [OffsetWidth-1:0] offset;
        logic [DataWidth-1:0]   wdata;
    } reg_req_t;

    typedef enum logic {
        PH_IDLE,
        PH_SETUP
    } apb_phase_e;

    typedef enum logic [OffsetWidth-1:0] {
        TMR_CTRL    = 4'd0,  // Bit 0 enables counting
        TMR_COUNT   = 4'd1,
        TMR_COMPARE = 4'd2,
        TMR_STATUS  = 4'd3   // Writing 1 to bit 0 clears the match flag
    } timer_reg_e;

    typedef enum logic [OffsetWidth-1:0] {
        IRQ_PRIO0     = 4'd0,   // One word per source from here
        IRQ_ENABLE    = 4'd8,
        IRQ_THRESHOLD = 4'd9,
        IRQ_CLAIM     = 4'd10   // Read claims, write completes
    } irq_reg_e;

endpackage

/* hw/apb_periph_decode.sv */
// APB slave front end of the peripheral subsystem.
// Splits the address into region and word offset, raises one register
// request per access phase and returns the selected read word.

`timescale 1ns/10ps

module apb_periph_decode (
    input  logic                                          clk_i,
    input  logic                                          rst_i,
    input  periph_pkg::apb_req_t                          apb_req_i,
    output periph_pkg::apb_rsp_t                          apb_rsp_o,
    output periph_pkg::reg_req_t [periph_pkg::NumTimers-1:0] tmr_req_o,
    input  logic [periph_pkg::NumTimers-1:0][periph_pkg::DataWidth-1:0] tmr_rdata_i,
    output periph_pkg::reg_req_t                          irq_req_o,
    input  logic [periph_pkg::DataWidth-1:0]              irq_rdata_i
);

    import periph_pkg::*;

    apb_phase_e             phase_q;
    logic                   access;
    logic [RegionWidth-1:0] region;
    logic                   tmr_hit;
    logic                   irq_hit;
    logic [DataWidth-1:0]   rd_word;
    reg_req_t               req_base;

    // ----------------------------------------------------------------------
    // Phase tracking
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            phase_q <= PH_IDLE;
        end else if (apb_req_i.psel && !apb_req_i.penable) begin
            phase_q <= PH_SETUP;
        end else begin
            phase_q <= PH_IDLE;
        end
    end

    // Access phase only counts after a setup phase
    assign access = (phase_q == PH_SETUP) && apb_req_i.psel && apb_req_i.penable;

    assign region  = apb_req_i.paddr[RegionLsb +: RegionWidth];
    assign tmr_hit = (region < RegionWidth'(NumTimers));
    assign irq_hit = (region == RegionWidth'(IrqRegion));

    // ----------------------------------------------------------------------
    // Register requests
    // ----------------------------------------------------------------------
    always_comb begin
        req_base.valid  = 1'b0;
        req_base.write  = apb_req_i.pwrite;
        req_base.offset = apb_req_i.paddr[OffsetLsb +: OffsetWidth];
        req_base.wdata  = apb_req_i.pwdata;

        for (int i = 0; i < NumTimers; i++) begin
            tmr_req_o[i]       = req_base;
            tmr_req_o[i].valid = access && (region == RegionWidth'(i));
        end

        irq_req_o       = req_base;
        irq_req_o.valid = access && irq_hit;
    end

    // Unmapped regions read as zero
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < NumTimers; i++) begin
            if (region == RegionWidth'(i)) begin
                rd_word = tmr_rdata_i[i];
            end
        end
        if (irq_hit) begin
            rd_word = irq_rdata_i;
        end
    end

    // ----------------------------------------------------------------------
    // Response
    // ----------------------------------------------------------------------
    assign apb_rsp_o.pready  = access;                        // No wait states
    assign apb_rsp_o.pslverr = access && !(tmr_hit || irq_hit);
    assign apb_rsp_o.prdata  = (access && !apb_req_i.pwrite) ? rd_word : '0;

endmodule

/* hw/timer_channel.sv */
// One timer channel. Counts while enabled, wraps to zero on compare and
// sets a sticky match flag that doubles as its interrupt level.
// Registers are reached through a reg_req_t from the APB decoder.

`timescale 1ns/10ps

module timer_channel (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  periph_pkg::reg_req_t            req_i,
    output logic [periph_pkg::DataWidth-1:0] rdata_o,
    output logic                            irq_o
);

    import periph_pkg::*;

    logic                 enable_q;
    logic [DataWidth-1:0] count_q;
    logic [DataWidth-1:0] compare_q;
    logic                 match_q;
    logic                 wr;
    logic                 hit;

    assign wr  = req_i.valid && req_i.write;
    assign hit = enable_q && (count_q == compare_q);

    // ----------------------------------------------------------------------
    // Register state
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            enable_q  <= 1'b0;
            count_q   <= '0;
            compare_q <= '0;
            match_q   <= 1'b0;
        end else begin
            if (wr && req_i.offset == TMR_CTRL) begin
                enable_q <= req_i.wdata[0];
            end

            // Software load wins over counting
            if (wr && req_i.offset == TMR_COUNT) begin
                count_q <= req_i.wdata;
            end else if (hit) begin
                count_q <= '0;
            end else if (enable_q) begin
                count_q <= count_q + 1'b1;
            end

            if (wr && req_i.offset == TMR_COMPARE) begin
                compare_q <= req_i.wdata;
            end

            if (hit) begin
                match_q <= 1'b1;  // New match beats a clear
            end else if (wr && req_i.offset == TMR_STATUS && req_i.wdata[0]) begin
                match_q <= 1'b0;
            end
        end
    end

    // Read word
    always_comb begin
        case (req_i.offset)
            TMR_CTRL:    rdata_o = DataWidth'(enable_q);
            TMR_COUNT:   rdata_o = count_q;
            TMR_COMPARE: rdata_o = compare_q;
            TMR_STATUS:  rdata_o = DataWidth'(match_q);
            default:     rdata_o = '0;
        endcase
    end

    assign irq_o = match_q;  // Level source

endmodule

/* hw/irq_controller.sv */
// Level triggered interrupt controller for the timer sources.
// Per source priority, one enable mask, a threshold and a claim/complete
// register. Drives a single registered interrupt line to the core.

`timescale 1ns/10ps

module irq_controller (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  periph_pkg::reg_req_t             req_i,
    output logic [periph_pkg::DataWidth-1:0] rdata_o,
    input  logic [periph_pkg::NumTimers-1:0] src_i,
    output logic                             irq_o
);

    import periph_pkg::*;

    logic [PrioWidth-1:0]  prio_q [NumTimers];
    logic [NumTimers-1:0]  enable_q;
    logic [PrioWidth-1:0]  threshold_q;
    logic [NumTimers-1:0]  in_service_q;
    logic                  irq_q;

    logic [NumTimers-1:0]  pending;
    logic [SrcIdWidth-1:0] claim_id;
    logic [PrioWidth-1:0]  best_prio;
    logic [SrcIdWidth-1:0] done_id;
    logic                  wr;
    logic                  claim_rd;
    logic                  complete_wr;

    assign wr          = req_i.valid && req_i.write;
    assign claim_rd    = req_i.valid && !req_i.write && (req_i.offset == IRQ_CLAIM);
    assign complete_wr = wr && (req_i.offset == IRQ_CLAIM);
    assign done_id     = req_i.wdata[SrcIdWidth-1:0];

    // Gateway blocks a source while it is in service
    assign pending = src_i & ~in_service_q & enable_q;

    // ----------------------------------------------------------------------
    // Priority scan
    // ----------------------------------------------------------------------
    always_comb begin
        claim_id  = '0;
        best_prio = threshold_q;
        // Strict compare keeps ties on the lowest id
        for (int i = 0; i < NumTimers; i++) begin
            if (pending[i] && prio_q[i] > best_prio) begin
                claim_id  = SrcIdWidth'(i + 1);
                best_prio = prio_q[i];
            end
        end
    end

    // ----------------------------------------------------------------------
    // Register state
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NumTimers; i++) begin
                prio_q[i] <= '0;
            end
            enable_q     <= '0;
            threshold_q  <= '0;
            in_service_q <= '0;
            irq_q        <= 1'b0;
        end else begin
            for (int i = 0; i < NumTimers; i++) begin
                if (wr && req_i.offset == OffsetWidth'(IRQ_PRIO0) + OffsetWidth'(i)) begin
                    prio_q[i] <= req_i.wdata[PrioWidth-1:0];
                end
                if (claim_rd && claim_id == SrcIdWidth'(i + 1)) begin
                    in_service_q[i] <= 1'b1;
                end else if (complete_wr && done_id == SrcIdWidth'(i + 1)) begin
                    in_service_q[i] <= 1'b0;
                end
            end

            if (wr && req_i.offset == IRQ_ENABLE) begin
                enable_q <= req_i.wdata[NumTimers-1:0];
            end
            if (wr && req_i.offset == IRQ_THRESHOLD) begin
                threshold_q <= req_i.wdata[PrioWidth-1:0];
            end

            irq_q <= (claim_id != '0);
        end
    end

    // Read word
    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < NumTimers; i++) begin
            if (req_i.offset == OffsetWidth'(IRQ_PRIO0) + OffsetWidth'(i)) begin
                rdata_o = DataWidth'(prio_q[i]);
            end
        end
        case (req_i.offset)
            IRQ_ENABLE:    rdata_o = DataWidth'(enable_q);
            IRQ_THRESHOLD: rdata_o = DataWidth'(threshold_q);
            IRQ_CLAIM:     rdata_o = DataWidth'(claim_id);
            default:       ;
        endcase
    end

    assign irq_o = irq_q;

endmodule

/* hw/periph_subsys.sv */
// Top of the peripheral subsystem. One APB slave port in front of
// NumTimers timer channels and the interrupt controller they feed.

`timescale 1ns/10ps

module periph_subsys (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  periph_pkg::apb_req_t apb_req_i,
    output periph_pkg::apb_rsp_t apb_rsp_o,
    output logic                 irq_o
);

    import periph_pkg::*;

    reg_req_t [NumTimers-1:0]                tmr_req;
    logic     [NumTimers-1:0][DataWidth-1:0] tmr_rdata;
    logic     [NumTimers-1:0]                tmr_irq;
    reg_req_t                                irq_req;
    logic     [DataWidth-1:0]                irq_rdata;

    apb_periph_decode i_decode (
        .clk_i       ( clk_i     ),
        .rst_i       ( rst_i     ),
        .apb_req_i   ( apb_req_i ),
        .apb_rsp_o   ( apb_rsp_o ),
        .tmr_req_o   ( tmr_req   ),
        .tmr_rdata_i ( tmr_rdata ),
        .irq_req_o   ( irq_req   ),
        .irq_rdata_i ( irq_rdata )
    );

    for (genvar i = 0; i < NumTimers; i++) begin : gen_timer
        timer_channel i_timer (
            .clk_i   ( clk_i        ),
            .rst_i   ( rst_i        ),
            .req_i   ( tmr_req[i]   ),
            .rdata_o ( tmr_rdata[i] ),
            .irq_o   ( tmr_irq[i]   )  // Source id i+1
        );
    end

    irq_controller i_irq (
        .clk_i   ( clk_i     ),
        .rst_i   ( rst_i     ),
        .req_i   ( irq_req   ),
        .rdata_o ( irq_rdata ),
        .src_i   ( tmr_irq   ),
        .irq_o   ( irq_o     )
    );

endmodule

/* verif/periph_subsys_sva.sv */
// Assertions bound into the peripheral subsystem top level.
// Checks the APB response rules and the interrupt line against the
// timer source levels.

`timescale 1ns/10ps

module periph_subsys_sva (
    input logic                             clk_i,
    input logic                             rst_i,
    input periph_pkg::apb_req_t             apb_req_i,
    input periph_pkg::apb_rsp_t             apb_rsp_o,
    input logic [periph_pkg::NumTimers-1:0] src_i,
    input logic                             irq_o
);

    import periph_pkg::*;

    logic [RegionWidth-1:0] region;
    logic                   unmapped;
    logic                   access;

    assign region   = apb_req_i.paddr[RegionLsb +: RegionWidth];
    assign unmapped = (region >= RegionWidth'(NumTimers)) && (region != RegionWidth'(IrqRegion));
    assign access   = apb_req_i.psel && apb_req_i.penable;

    // ----------------------------------------------------------------------
    // APB response
    // ----------------------------------------------------------------------
    reset_quiet: assert property (@(posedge clk_i)
        rst_i |=> !irq_o && !apb_rsp_o.pready && !apb_rsp_o.pslverr)
        else $error("outputs not low after reset");

    ready_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
        apb_rsp_o.pready |-> access)
        else $error("pready outside an access phase");

    ready_after_setup: assert property (@(posedge clk_i) disable iff (rst_i)
        access && $past(apb_req_i.psel && !apb_req_i.penable) |-> apb_rsp_o.pready)
        else $error("access phase without pready");

    err_on_unmapped: assert property (@(posedge clk_i) disable iff (rst_i)
        apb_rsp_o.pready |-> (apb_rsp_o.pslverr == unmapped))
        else $error("pslverr does not match the address map");

    err_with_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        apb_rsp_o.pslverr |-> apb_rsp_o.pready)
        else $error("pslverr outside an access phase");

    unmapped_read_zero: assert property (@(posedge clk_i) disable iff (rst_i)
        apb_rsp_o.pslverr && !apb_req_i.pwrite |-> apb_rsp_o.prdata == '0)
        else $error("unmapped read returned nonzero data");

    // No source level means no interrupt one cycle later
    irq_needs_source: assert property (@(posedge clk_i) disable iff (rst_i)
        !(|src_i) |=> !irq_o)
        else $error("irq_o high without any source level");

endmodule

/* verif/tb_periph_subsys.sv */
// Testbench for the peripheral subsystem. Drives the APB port through
// reset, bus response, register read-back, timer match and claim tests.
// Protocol and interrupt level rules are checked by the bound SVA module.

`timescale 1ns/10ps

module tb_periph_subsys;

    import periph_pkg::*;

    localparam int XferCycles     = 3;    // Setup, access, idle
    localparam int TestXfers      = 400;
    localparam int WatchdogCycles = 2 * TestXfers * XferCycles + 600;
    localparam int PollLimit      = 64;

    logic     clk = 1'b0;
    logic     rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     irq;
    int       errors = 0;
    int       checks = 0;
    integer   seed   = 32'h89b78921;

    periph_subsys dut0 (
        .clk_i     ( clk     ),
        .rst_i     ( rst     ),
        .apb_req_i ( apb_req ),
        .apb_rsp_o ( apb_rsp ),
        .irq_o     ( irq     )
    );

    bind periph_subsys periph_subsys_sva sva0 (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .apb_req_i ( apb_req_i ),
        .apb_rsp_o ( apb_rsp_o ),
        .src_i     ( tmr_irq   ),
        .irq_o     ( irq_o     )
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] tmr_addr(input int ch, input int off);
        return 32'((ch << RegionLsb) | (off << OffsetLsb));
    endfunction

    function automatic logic [31:0] irq_addr(input int off);
        return 32'((IrqRegion << RegionLsb) | (off << OffsetLsb));
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("FAIL %s: got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            $display("ERROR: %s", what);
            errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // APB driver
    // ----------------------------------------------------------------------
    task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);  // Access phase settled
        check_true(apb_rsp.pready, $sformatf("no pready in access phase at %h", addr));
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, wdata, rd, err);
        check_true(!err, $sformatf("unexpected pslverr on write to %h", addr));
    endtask

    task automatic read_reg(input logic [31:0] addr, input string name,
                            input logic [31:0] expected);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, '0, rd, err);
        check_true(!err, $sformatf("unexpected pslverr on read of %h", addr));
        check_value(name, rd, expected);
    endtask

    task automatic settle();
        repeat (2) @(posedge clk);
        #1;
    endtask

    // Run a channel up to compare c, then stop it with the flag still set
    task automatic raise_flag(input int ch, input logic [31:0] c);
        logic [31:0] rd;
        logic        err;
        int          polls;
        write_reg(tmr_addr(ch, TMR_COMPARE), c);
        write_reg(tmr_addr(ch, TMR_COUNT), '0);
        write_reg(tmr_addr(ch, TMR_CTRL), 32'd1);
        polls = 0;
        rd    = '0;
        while (rd[0] !== 1'b1 && polls < PollLimit) begin
            apb_xfer(1'b0, tmr_addr(ch, TMR_STATUS), '0, rd, err);
            polls++;
        end
        check_true(rd[0] === 1'b1, $sformatf("timer %0d match flag never set", ch));
        apb_xfer(1'b0, tmr_addr(ch, TMR_COUNT), '0, rd, err);
        checks++;
        assert (rd <= c) else begin
            $display("FAIL tmr%0d.count: got %h above compare %h", ch, rd, c);
            errors++;
        end
        write_reg(tmr_addr(ch, TMR_CTRL), '0);
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        logic [31:0] rd;
        logic [31:0] v;
        logic        err;
        int          claim_ids [4];
        apb_req = '0;
        rst     = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_true(!irq && !apb_rsp.pready && !apb_rsp.pslverr, "outputs not low after reset");
        for (int ch = 0; ch < NumTimers; ch++) begin
            for (int off = 0; off < 4; off++) begin
                read_reg(tmr_addr(ch, off), $sformatf("tmr%0d.reg%0d", ch, off), '0);
            end
            read_reg(irq_addr(IRQ_PRIO0 + ch), $sformatf("irq.prio%0d", ch), '0);
        end
        read_reg(irq_addr(IRQ_ENABLE), "irq.enable", '0);
        read_reg(irq_addr(IRQ_THRESHOLD), "irq.threshold", '0);
        read_reg(irq_addr(IRQ_CLAIM), "irq.claim", '0);

        // Unmapped regions 4, 9 and 14
        for (int r = NumTimers; r < IrqRegion; r += 5) begin
            v = $random(seed);
            apb_xfer(1'b1, 32'(r << RegionLsb), v, rd, err);
            check_true(err, $sformatf("no pslverr on write to unmapped region %0d", r));
            apb_xfer(1'b0, 32'(r << RegionLsb), '0, rd, err);
            check_true(err, $sformatf("no pslverr on read of unmapped region %0d", r));
            check_value("prdata", rd, '0);
        end

        for (int ch = 0; ch < NumTimers; ch++) begin
            v = $random(seed);
            write_reg(tmr_addr(ch, TMR_COMPARE), v);
            read_reg(tmr_addr(ch, TMR_COMPARE), $sformatf("tmr%0d.compare", ch), v);
            v = $random(seed);
            write_reg(irq_addr(IRQ_PRIO0 + ch), v);
            read_reg(irq_addr(IRQ_PRIO0 + ch), $sformatf("irq.prio%0d", ch), v & MaxPrio);
        end
        v = $random(seed);
        write_reg(irq_addr(IRQ_ENABLE), v);
        read_reg(irq_addr(IRQ_ENABLE), "irq.enable", v & ((1 << NumTimers) - 1));
        v = $random(seed);
        write_reg(irq_addr(IRQ_THRESHOLD), v);
        read_reg(irq_addr(IRQ_THRESHOLD), "irq.threshold", v & MaxPrio);
        write_reg(irq_addr(IRQ_ENABLE), '0);

        for (int ch = 0; ch < NumTimers; ch++) begin
            raise_flag(ch, 32'd4 + ($unsigned($random(seed)) % 16));
            write_reg(tmr_addr(ch, TMR_STATUS), 32'd1);
            read_reg(tmr_addr(ch, TMR_STATUS), $sformatf("tmr%0d.status", ch), '0);
        end

        // Ids 2 and 3 tie at 5 and id 4 sits at the threshold
        write_reg(irq_addr(IRQ_PRIO0 + 0), 32'd3);
        write_reg(irq_addr(IRQ_PRIO0 + 1), 32'd5);
        write_reg(irq_addr(IRQ_PRIO0 + 2), 32'd5);
        write_reg(irq_addr(IRQ_PRIO0 + 3), 32'd1);
        write_reg(irq_addr(IRQ_THRESHOLD), 32'd1);
        write_reg(irq_addr(IRQ_ENABLE), 32'hf);
        for (int ch = 0; ch < NumTimers; ch++) begin
            raise_flag(ch, 32'd2 + 32'(ch));
        end
        settle();
        check_value("irq_o", 32'(irq), 32'd1);
        claim_ids = '{2, 3, 1, 0};
        for (int k = 0; k < 4; k++) begin
            read_reg(irq_addr(IRQ_CLAIM), "irq.claim", 32'(claim_ids[k]));
            settle();
            check_value("irq_o", 32'(irq), (k < 2) ? 32'd1 : 32'd0);
        end

        for (int ch = 0; ch < NumTimers; ch++) begin
            write_reg(tmr_addr(ch, TMR_STATUS), 32'd1);
        end
        for (int id = 1; id <= NumTimers; id++) begin
            write_reg(irq_addr(IRQ_CLAIM), 32'(id));
        end
        settle();
        check_value("irq_o", 32'(irq), '0);
        read_reg(irq_addr(IRQ_CLAIM), "irq.claim", '0);
        repeat (5) @(posedge clk);
        #1;
        check_value("irq_o", 32'(irq), '0);

        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, test did not finish", WatchdogCycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* verilog.f */
hw/periph_pkg.sv
hw/apb_periph_decode.sv
hw/timer_channel.sv
hw/irq_controller.sv
hw/periph_subsys.sv
verif/periph_subsys_sva.sv
verif/tb_periph_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the peripheral subsystem testbench with Verilator.
set -u
cd "$(dirname "$0")"

TOP=tb_periph_subsys
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module "$TOP" -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
exit 0
